//--- run_sim.sh
#!/usr/bin/env bash
# build and run the l2 cache testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD=build
LOG="$BUILD/sim.log"

mkdir -p "$BUILD"
if [ $? -ne 0 ]; then
    echo "could not create $BUILD"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f sim.f --top-module l2_tb -Mdir "$BUILD/obj"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"$BUILD/obj/Vl2_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+source
source/l2_pkg.sv
source/l2_array_if.sv
source/l2_req_buf.sv
source/l2_plru.sv
source/l2_arrays.sv
source/l2_ctrl_fsm.sv
source/l2_cache_top.sv
sim/l2_mem_model.sv
sim/l2_tb.sv

//--- sim/l2_mem_model.sv
// line-wide memory responder
`include "l2_cfg.svh"

module l2_mem_model (
    input  logic          clk,
    input  logic          rstn,
    input  logic          mem_rd_req,
    input  logic          mem_wr_req,
    input  l2_pkg::word_t mem_addr,
    input  l2_pkg::line_t mem_wdata,
    output logic          mem_addr_ok,
    input  logic          mem_rdy,
    output logic          mem_data_ok,
    output l2_pkg::line_t mem_rdata
);
    import l2_pkg::*;

    localparam int LATENCY = 2;

    // written-back lines, keyed by line address
    line_t store [word_t];
    word_t rd_addr;
    int    cnt;

    // takes a new request whenever no refill is pending
    assign mem_addr_ok = (mem_rd_req | mem_wr_req) & (cnt == 0);

    // untouched words read back as a pattern of their own address
    function automatic line_t read_line(input word_t base);
        line_t l;
        word_t a;
        for (int w = 0; w < `L2_WORDS; w++) begin
            a    = base + word_t'(4 * w);
            l[w] = a ^ 32'h5a5a_0000;
        end
        if (store.exists(base)) begin
            l = store[base];
        end
        return l;
    endfunction

    // a write-back is done once it is accepted
    always @(posedge clk) begin
        if (rstn && mem_wr_req && mem_addr_ok) begin
            store[mem_addr] = mem_wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt         <= 0;
            rd_addr     <= '0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            mem_data_ok <= 1'b0;
            if (cnt > 1) begin
                cnt <= cnt - 1;
            end else if (cnt == 1) begin
                // line goes out only while the cache waits for it
                if (mem_rdy) begin
                    cnt         <= 0;
                    mem_data_ok <= 1'b1;
                    mem_rdata   <= read_line(rd_addr);
                end
            end else if (mem_rd_req && mem_addr_ok) begin
                rd_addr <= mem_addr;
                cnt     <= LATENCY;
            end
        end
    end

endmodule

//--- sim/l2_tb.sv
// l2 cache testbench
`include "l2_cfg.svh"

module l2_tb;
    import l2_pkg::*;

    typedef struct packed {
        logic  dc;
        logic  we;
        word_t addr;
        word_t wdata;
        word_t exp;
        logic  chk_hit;
        logic  with_next;
    } entry_t;

    logic  clk;
    logic  rstn;
    logic  ic_req;
    word_t ic_addr;
    logic  ic_addr_ok;
    logic  ic_data_ok;
    word_t ic_rdata;
    logic  dc_req;
    logic  dc_we;
    word_t dc_addr;
    word_t dc_wdata;
    logic  dc_addr_ok;
    logic  dc_data_ok;
    word_t dc_rdata;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t mem_addr;
    line_t mem_wdata;
    logic  mem_addr_ok;
    logic  mem_rdy;
    logic  mem_data_ok;
    line_t mem_rdata;

    entry_t tbl [$];
    logic   table_ready;
    word_t  shadow [word_t];
    int     acc_cyc [int];
    int     done_cyc [int];
    int     cyc;
    int     wb_count;
    int     word_errs;
    int     line_errs;
    int     bit_errs;
    int     count_errs;

    l2_cache_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .ic_req      (ic_req),
        .ic_addr     (ic_addr),
        .ic_addr_ok  (ic_addr_ok),
        .ic_data_ok  (ic_data_ok),
        .ic_rdata    (ic_rdata),
        .dc_req      (dc_req),
        .dc_we       (dc_we),
        .dc_addr     (dc_addr),
        .dc_wdata    (dc_wdata),
        .dc_addr_ok  (dc_addr_ok),
        .dc_data_ok  (dc_data_ok),
        .dc_rdata    (dc_rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_rdy     (mem_rdy),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    l2_mem_model i_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_rdy     (mem_rdy),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("** Error @%0t: %s got %h expected %h", $time, msg, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string msg);
        if (got !== exp) begin
            $display("** Error @%0t: %s got %h expected %h", $time, msg, got, exp);
            line_errs++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("** Error @%0t: %s got %b expected %b", $time, msg, got, exp);
            bit_errs++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("** Error @%0t: %s got %0d expected %0d", $time, msg, got, exp);
            count_errs++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    // what memory holds at a word that was never written
    function automatic word_t mem_pattern(input word_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic add(input logic dc, input logic we, input word_t addr, input word_t wdata,
                       input word_t exp, input logic chk_hit, input logic with_next);
        entry_t e;
        e.dc        = dc;
        e.we        = we;
        e.addr      = addr;
        e.wdata     = wdata;
        e.exp       = exp;
        e.chk_hit   = chk_hit;
        e.with_next = with_next;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // read miss then hits on the same line
        add(0, 0, 32'h0000_1034, 0, mem_pattern(32'h0000_1034), 0, 0);
        add(0, 0, 32'h0000_1034, 0, mem_pattern(32'h0000_1034), 1, 0);
        add(1, 0, 32'h0000_1038, 0, mem_pattern(32'h0000_1038), 1, 0);
        // write hit leaves the neighbours untouched
        add(1, 1, 32'h0000_1038, 32'hcafe_0001, 0, 1, 0);
        add(1, 0, 32'h0000_1038, 0, 32'hcafe_0001, 1, 0);
        add(1, 0, 32'h0000_103c, 0, mem_pattern(32'h0000_103c), 1, 0);
        add(1, 0, 32'h0000_1030, 0, mem_pattern(32'h0000_1030), 1, 0);
        // write miss allocates
        add(1, 1, 32'h0000_2044, 32'h1234_5678, 0, 0, 0);
        add(1, 0, 32'h0000_2044, 0, 32'h1234_5678, 1, 0);
        add(1, 0, 32'h0000_2040, 0, mem_pattern(32'h0000_2040), 1, 0);
        add(1, 0, 32'h0000_204c, 0, mem_pattern(32'h0000_204c), 1, 0);
        // five tags into set 6
        add(1, 1, 32'h0000_a160, 32'hd000_0001, 0, 0, 0);
        add(1, 1, 32'h0000_b164, 32'hd000_0002, 0, 0, 0);
        add(1, 1, 32'h0000_c168, 32'hd000_0003, 0, 0, 0);
        add(1, 1, 32'h0000_d16c, 32'hd000_0004, 0, 0, 0);
        add(1, 1, 32'h0000_e160, 32'hd000_0005, 0, 0, 0);
        add(1, 0, 32'h0000_a160, 0, 32'hd000_0001, 0, 0);
        add(1, 0, 32'h0000_b164, 0, 32'hd000_0002, 0, 0);
        add(1, 0, 32'h0000_c168, 0, 32'hd000_0003, 0, 0);
        add(1, 0, 32'h0000_d16c, 0, 32'hd000_0004, 0, 0);
        add(1, 0, 32'h0000_e160, 0, 32'hd000_0005, 0, 0);
        add(1, 0, 32'h0000_a164, 0, mem_pattern(32'h0000_a164), 0, 0);
        // both sides at once and the icache reads the dcache write
        add(1, 1, 32'h0000_3084, 32'h7777_0006, 0, 0, 1);
        add(0, 0, 32'h0000_3084, 0, 32'h7777_0006, 1, 0);
    endtask

    ////////////////////////////////////////
    // requester handshake
    ////////////////////////////////////////

    task automatic drive_req(input int n);
        entry_t e;
        int     t_acc;
        logic   ok;
        e = tbl[n];
        @(posedge clk);
        if (e.dc) begin
            dc_req   <= 1'b1;
            dc_we    <= e.we;
            dc_addr  <= e.addr;
            dc_wdata <= e.wdata;
        end else begin
            ic_req  <= 1'b1;
            ic_addr <= e.addr;
        end
        // held until addr_ok
        do begin
            @(posedge clk);
            ok = e.dc ? (dc_req & dc_addr_ok) : (ic_req & ic_addr_ok);
        end while (!ok);
        t_acc      = cyc;
        acc_cyc[n] = t_acc;
        if (e.we) begin
            shadow[e.addr] = e.wdata;
        end
        if (e.dc) begin
            dc_req <= 1'b0;
        end else begin
            ic_req <= 1'b0;
        end
        do begin
            @(posedge clk);
            ok = e.dc ? dc_data_ok : ic_data_ok;
        end while (!ok);
        done_cyc[n] = cyc;
        if (!e.we) begin
            check_word(e.dc ? dc_rdata : ic_rdata, e.exp, "read data");
        end
        if (e.chk_hit) begin
            check_count(cyc - t_acc, 1, "hit latency");
        end
    endtask

    // edge where both requests are first seen
    task automatic check_priority();
        @(posedge clk);
        @(posedge clk);
        check_bit(dc_addr_ok, 1'b1, "dc_addr_ok on a tie");
        check_bit(ic_addr_ok, 1'b0, "ic_addr_ok on a tie");
    endtask

    // every write-back line against the shadow
    always @(posedge clk) begin
        line_t exp_line;
        word_t a;
        if (rstn && mem_wr_req && mem_addr_ok) begin
            for (int w = 0; w < `L2_WORDS; w++) begin
                a           = mem_addr + word_t'(4 * w);
                exp_line[w] = shadow.exists(a) ? shadow[a] : mem_pattern(a);
            end
            check_line(mem_wdata, exp_line, "write-back line");
            wb_count++;
        end
    end

    initial begin
        wait (table_ready);
        #(tbl.size() * 60 * 100);
        $display("timeout: the cache did not finish the test table in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int i;
        int total;
        word_errs  = 0;
        line_errs  = 0;
        bit_errs   = 0;
        count_errs = 0;
        wb_count   = 0;
        rstn     <= 1'b0;
        ic_req   <= 1'b0;
        ic_addr  <= '0;
        dc_req   <= 1'b0;
        dc_we    <= 1'b0;
        dc_addr  <= '0;
        dc_wdata <= '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].with_next) begin
                fork
                    drive_req(i);
                    drive_req(i + 1);
                    check_priority();
                join
                check_bit(acc_cyc[i + 1] > done_cyc[i], 1'b1, "icache served after dcache");
                i += 2;
            end else begin
                drive_req(i);
                i += 1;
            end
        end
        repeat (4) @(posedge clk);
        check_bit(wb_count > 0, 1'b1, "dirty eviction seen");
        total = word_errs + line_errs + bit_errs + count_errs;
        $display("errors: word %0d, line %0d, handshake %0d, latency %0d (write-backs %0d)",
                 word_errs, line_errs, bit_errs, count_errs, wb_count);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- source/l2_array_if.sv
// l2 array access bundle
`include "l2_cfg.svh"

interface l2_array_if;
    import l2_pkg::*;

    // controller to arrays
    logic [`L2_INDEX_WIDTH-1:0]  index;
    tag_t                        tag;
    logic [`L2_OFFSET_WIDTH-1:0] offset;
    word_t                       wr_word;
    line_t                       refill_line;
    way_mask_t                   data_we;
    logic                        install;
    tag_t                        install_tag;
    logic                        dirty_set;
    logic                        dirty_clr;
    way_t                        way_sel;

    // arrays to controller
    way_mask_t hit;
    word_t     hit_word;
    tag_t      victim_tag;
    line_t     victim_line;
    logic      victim_dirty;

    modport ctrl (
        output index, tag, offset, wr_word, refill_line, data_we, install,
        output install_tag, dirty_set, dirty_clr, way_sel,
        input  hit, hit_word, victim_tag, victim_line, victim_dirty
    );

    modport array (
        input  index, tag, offset, wr_word, refill_line, data_we, install,
        input  install_tag, dirty_set, dirty_clr, way_sel,
        output hit, hit_word, victim_tag, victim_line, victim_dirty
    );

endinterface

//--- source/l2_arrays.sv
// l2 tag and data storage
`include "l2_cfg.svh"

module l2_arrays (
    input logic       clk,
    input logic       rstn,
    l2_array_if.array arr
);
    import l2_pkg::*;

    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    logic [`L2_WAYS-1:0] valid_q [SETS];
    logic [`L2_WAYS-1:0] dirty_q [SETS];
    tag_t                tag_q   [SETS][`L2_WAYS];
    line_t               data_q  [SETS][`L2_WAYS];

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // at most one way matches, so or-ing the words is a mux
    always_comb begin
        arr.hit      = '0;
        arr.hit_word = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (valid_q[arr.index][w] && (tag_q[arr.index][w] == arr.tag)) begin
                arr.hit[w]   = 1'b1;
                arr.hit_word = arr.hit_word | data_q[arr.index][w][arr.offset];
            end
        end
    end

    // victim readout for write-back
    assign arr.victim_tag   = tag_q[arr.index][arr.way_sel];
    assign arr.victim_line  = data_q[arr.index][arr.way_sel];
    assign arr.victim_dirty = dirty_q[arr.index][arr.way_sel];

    ////////////////////////////////////////
    // state bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (arr.install) begin
                valid_q[arr.index] <= valid_q[arr.index] | arr.data_we;
            end
            // set wins, both never come together
            if (arr.dirty_set) begin
                dirty_q[arr.index][arr.way_sel] <= 1'b1;
            end else if (arr.dirty_clr) begin
                dirty_q[arr.index][arr.way_sel] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // tag and data
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (arr.data_we[w]) begin
                if (arr.install) begin
                    tag_q[arr.index][w]  <= arr.install_tag;
                    data_q[arr.index][w] <= arr.refill_line;
                end else begin
                    data_q[arr.index][w][arr.offset] <= arr.wr_word;
                end
            end
        end
    end

endmodule

//--- source/l2_cache_top.sv
// l2 cache top level
module l2_cache_top (
    input  logic          clk,
    input  logic          rstn,

    // icache side
    input  logic          ic_req,
    input  l2_pkg::word_t ic_addr,
    output logic          ic_addr_ok,
    output logic          ic_data_ok,
    output l2_pkg::word_t ic_rdata,

    // dcache side
    input  logic          dc_req,
    input  logic          dc_we,
    input  l2_pkg::word_t dc_addr,
    input  l2_pkg::word_t dc_wdata,
    output logic          dc_addr_ok,
    output logic          dc_data_ok,
    output l2_pkg::word_t dc_rdata,

    // memory side
    output logic          mem_rd_req,
    output logic          mem_wr_req,
    output l2_pkg::word_t mem_addr,
    output l2_pkg::line_t mem_wdata,
    input  logic          mem_addr_ok,
    output logic          mem_rdy,
    input  logic          mem_data_ok,
    input  l2_pkg::line_t mem_rdata
);
    import l2_pkg::*;

    logic      idle;
    logic      buf_we;
    req_src_t  src;
    l2_addr_u  addr;
    word_t     wdata;
    way_mask_t use_mask;
    way_t      victim;
    word_t     rdata;

    l2_array_if arr_if ();

    // one read data path feeds both requesters
    assign ic_rdata = rdata;
    assign dc_rdata = rdata;

    l2_req_buf i_req_buf (
        .clk        (clk),
        .rstn       (rstn),
        .ic_req     (ic_req),
        .ic_addr    (ic_addr),
        .dc_req     (dc_req),
        .dc_we      (dc_we),
        .dc_addr    (dc_addr),
        .dc_wdata   (dc_wdata),
        .idle       (idle),
        .ic_addr_ok (ic_addr_ok),
        .dc_addr_ok (dc_addr_ok),
        .buf_we     (buf_we),
        .src        (src),
        .addr       (addr),
        .wdata      (wdata)
    );

    l2_plru i_plru (
        .clk      (clk),
        .rstn     (rstn),
        .index    (addr.f.index),
        .use_mask (use_mask),
        .victim   (victim)
    );

    l2_arrays i_arrays (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr_if.array)
    );

    l2_ctrl_fsm i_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .buf_we      (buf_we),
        .src         (src),
        .addr        (addr),
        .wdata       (wdata),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .idle        (idle),
        .use_mask    (use_mask),
        .ic_data_ok  (ic_data_ok),
        .dc_data_ok  (dc_data_ok),
        .rdata       (rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rdy     (mem_rdy),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .arr         (arr_if.ctrl)
    );

endmodule

//--- source/l2_cfg.svh
// l2 cache geometry
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// 16 sets
`define L2_INDEX_WIDTH 4

// 4 words per line
`define L2_OFFSET_WIDTH 2

// associativity, power of two for the plru tree
`define L2_WAYS 4

// derived sizes
`define L2_WORDS (1 << `L2_OFFSET_WIDTH)
`define L2_TAG_WIDTH (32 - `L2_INDEX_WIDTH - `L2_OFFSET_WIDTH - 2)

`endif

//--- source/l2_ctrl_fsm.sv
// l2 cache controller
`include "l2_cfg.svh"

module l2_ctrl_fsm (
    input  logic              clk,
    input  logic              rstn,
    input  logic              buf_we,
    input  l2_pkg::req_src_t  src,
    input  l2_pkg::l2_addr_u  addr,
    input  l2_pkg::word_t     wdata,
    input  l2_pkg::way_t      victim,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok,
    input  l2_pkg::line_t     mem_rdata,
    output logic              idle,
    output l2_pkg::way_mask_t use_mask,
    output logic              ic_data_ok,
    output logic              dc_data_ok,
    output l2_pkg::word_t     rdata,
    output logic              mem_rd_req,
    output logic              mem_wr_req,
    output logic              mem_rdy,
    output l2_pkg::word_t     mem_addr,
    output l2_pkg::line_t     mem_wdata,
    l2_array_if.ctrl          arr
);
    import l2_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_CHECK_DIRTY,
        S_WRITEBACK,
        S_REFILL_REQ,
        S_REFILL_WAIT,
        S_ALLOC_WRITE
    } state_t;

    state_t    state;
    state_t    state_next;
    way_t      hit_way;
    way_mask_t victim_mask;
    l2_addr_u  wb_addr;
    l2_addr_u  fill_addr;
    logic      is_write;
    logic      is_ic;

    assign is_write    = (src == SRC_DC_WR);
    assign is_ic       = (src == SRC_IC_RD);
    assign victim_mask = way_mask_t'(1) << victim;
    assign idle        = (state == S_IDLE);

    ////////////////////////////////////////
    // array and memory datapath
    ////////////////////////////////////////

    assign arr.index       = addr.f.index;
    assign arr.tag         = addr.f.tag;
    assign arr.offset      = addr.f.offset;
    assign arr.wr_word     = wdata;
    assign arr.refill_line = mem_rdata;
    assign arr.install_tag = addr.f.tag;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (arr.hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // line addresses, offset and byte bits cleared
    always_comb begin
        wb_addr            = addr;
        wb_addr.f.tag      = arr.victim_tag;
        wb_addr.f.offset   = '0;
        wb_addr.f.byte_off = '0;
        fill_addr            = addr;
        fill_addr.f.offset   = '0;
        fill_addr.f.byte_off = '0;
    end

    assign mem_addr  = (state == S_WRITEBACK) ? wb_addr.raw : fill_addr.raw;
    assign mem_wdata = arr.victim_line;

    // refill returns the word straight from memory
    assign rdata = (state == S_REFILL_WAIT) ? mem_rdata[addr.f.offset] : arr.hit_word;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        use_mask      = '0;
        ic_data_ok    = 1'b0;
        dc_data_ok    = 1'b0;
        mem_rd_req    = 1'b0;
        mem_wr_req    = 1'b0;
        mem_rdy       = 1'b0;
        arr.data_we   = '0;
        arr.install   = 1'b0;
        arr.dirty_set = 1'b0;
        arr.dirty_clr = 1'b0;
        arr.way_sel   = victim;
        case (state)
            S_IDLE: begin
                if (buf_we) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (|arr.hit) begin
                    use_mask    = arr.hit;
                    arr.way_sel = hit_way;
                    if (is_write) begin
                        arr.data_we   = arr.hit;
                        arr.dirty_set = 1'b1;
                    end
                    ic_data_ok = is_ic;
                    dc_data_ok = ~is_ic;
                    state_next = S_IDLE;
                end else begin
                    state_next = S_CHECK_DIRTY;
                end
            end
            // victim way settled, read its dirty bit
            S_CHECK_DIRTY: begin
                state_next = arr.victim_dirty ? S_WRITEBACK : S_REFILL_REQ;
            end
            S_WRITEBACK: begin
                mem_wr_req = 1'b1;
                if (mem_addr_ok) begin
                    state_next = S_REFILL_REQ;
                end
            end
            S_REFILL_REQ: begin
                mem_rd_req = 1'b1;
                if (mem_addr_ok) begin
                    state_next = S_REFILL_WAIT;
                end
            end
            S_REFILL_WAIT: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    arr.data_we   = victim_mask;
                    arr.install   = 1'b1;
                    arr.dirty_clr = 1'b1;
                    if (is_write) begin
                        state_next = S_ALLOC_WRITE;
                    end else begin
                        use_mask   = victim_mask;
                        ic_data_ok = is_ic;
                        dc_data_ok = ~is_ic;
                        state_next = S_IDLE;
                    end
                end
            end
            // word goes into the freshly installed line
            S_ALLOC_WRITE: begin
                arr.data_we   = victim_mask;
                arr.dirty_set = 1'b1;
                use_mask      = victim_mask;
                dc_data_ok    = 1'b1;
                state_next    = S_IDLE;
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

//--- source/l2_pkg.sv
// l2 cache shared types
`include "l2_cfg.svh"

package l2_pkg;

    // one data word
    typedef logic [31:0] word_t;

    // a full line, word 0 in the low bits
    typedef logic [`L2_WORDS-1:0][31:0] line_t;

    typedef logic [`L2_TAG_WIDTH-1:0] tag_t;

    typedef logic [$clog2(`L2_WAYS)-1:0] way_t;

    // one bit per way
    typedef logic [`L2_WAYS-1:0] way_mask_t;

    // byte address split for the arrays
    typedef struct packed {
        tag_t                        tag;
        logic [`L2_INDEX_WIDTH-1:0]  index;
        logic [`L2_OFFSET_WIDTH-1:0] offset;
        logic [1:0]                  byte_off;
    } addr_fields_t;

    // raw view goes to memory, field view to the arrays
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } l2_addr_u;

    // source of the request in flight
    typedef enum logic [1:0] {
        SRC_NONE  = 2'b00,
        SRC_IC_RD = 2'b01,
        SRC_DC_RD = 2'b10,
        SRC_DC_WR = 2'b11
    } req_src_t;

endpackage

//--- source/l2_plru.sv
// l2 tree pseudo-lru
`include "l2_cfg.svh"

module l2_plru (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`L2_INDEX_WIDTH-1:0] index,
    input  l2_pkg::way_mask_t          use_mask,
    output l2_pkg::way_t               victim
);
    import l2_pkg::*;

    localparam int SETS   = 1 << `L2_INDEX_WIDTH;
    localparam int LEVELS = $clog2(`L2_WAYS);

    // heap order, node n has children 2n+1 and 2n+2
    logic [`L2_WAYS-2:0] tree_q [SETS];
    logic [`L2_WAYS-2:0] tree_next;
    way_t                pick;

    // follow the bits down to the victim leaf
    always_comb begin
        int node;
        node = 0;
        pick = '0;
        for (int l = 0; l < LEVELS; l++) begin
            pick[LEVELS-1-l] = tree_q[index][node];
            node = 2 * node + 1 + int'(tree_q[index][node]);
        end
    end

    // point every node on the used path the other way
    always_comb begin
        int   node;
        logic b;
        node      = 0;
        b         = 1'b0;
        tree_next = tree_q[index];
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (use_mask[w]) begin
                node = 0;
                for (int l = 0; l < LEVELS; l++) begin
                    b               = w[LEVELS-1-l];
                    tree_next[node] = ~b;
                    node            = 2 * node + 1 + int'(b);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
            victim <= '0;
        end else begin
            if (|use_mask) begin
                tree_q[index] <= tree_next;
            end
            victim <= pick;
        end
    end

endmodule

//--- source/l2_req_buf.sv
// l2 request arbiter and buffer
module l2_req_buf (
    input  logic             clk,
    input  logic             rstn,
    input  logic             ic_req,
    input  l2_pkg::word_t    ic_addr,
    input  logic             dc_req,
    input  logic             dc_we,
    input  l2_pkg::word_t    dc_addr,
    input  l2_pkg::word_t    dc_wdata,
    input  logic             idle,
    output logic             ic_addr_ok,
    output logic             dc_addr_ok,
    output logic             buf_we,
    output l2_pkg::req_src_t src,
    output l2_pkg::l2_addr_u addr,
    output l2_pkg::word_t    wdata
);
    import l2_pkg::*;

    req_src_t win_src;

    // dcache wins a tie
    assign dc_addr_ok = idle;
    assign ic_addr_ok = idle & ~dc_req;

    always_comb begin
        if (dc_req) begin
            win_src = dc_we ? SRC_DC_WR : SRC_DC_RD;
        end else if (ic_req) begin
            win_src = SRC_IC_RD;
        end else begin
            win_src = SRC_NONE;
        end
    end

    assign buf_we = idle & (win_src != SRC_NONE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            src <= SRC_NONE;
        end else if (buf_we) begin
            src <= win_src;
        end
    end

    // held for the whole transaction
    always_ff @(posedge clk) begin
        if (buf_we) begin
            addr.raw <= dc_req ? dc_addr : ic_addr;
            wdata    <= dc_wdata;
        end
    end

endmodule
